// ==== loop_pred_config.svh ====
`ifndef LOOP_PRED_CONFIG_SVH
`define LOOP_PRED_CONFIG_SVH

// Address and instruction geometry.
`define LP_PLEN 32
`define LP_ILEN 32
`define LP_SLOTS 2

// Both tables are direct-mapped with this many entries.
`define LP_ENTRIES 64
`define LP_IDX_BITS 6
`define LP_TAG_BITS 10

// Loop entry field widths.
`define LP_ITER_BITS 8
`define LP_CONF_BITS 2

// Confidence at or above this level makes the loop prediction win.
`define LP_CONF_THRESH 2

// The bimodal counter width and its value after reset (weakly not-taken).
`define LP_BIM_BITS 2
`define LP_BIM_INIT 1

`endif

// ==== loop_pred_pkg.sv ====
`include "loop_pred_config.svh"

package loop_pred_pkg;

  // Full program counter.
  typedef logic [`LP_PLEN-1:0] pc_t;

  // One bit per instruction slot of a fetch block.
  typedef logic [`LP_SLOTS-1:0] slot_mask_t;

  // Direct-mapped table index and the tag stored alongside it.
  typedef logic [`LP_IDX_BITS-1:0] lp_idx_t;
  typedef logic [`LP_TAG_BITS-1:0] lp_tag_t;

  // Trip count and running iteration count of a loop entry.
  typedef logic [`LP_ITER_BITS-1:0] iter_t;

  // Confidence that the stored trip count repeats.
  typedef logic [`LP_CONF_BITS-1:0] conf_t;

  // Two-bit saturating direction counter.
  typedef logic [`LP_BIM_BITS-1:0] bim_ctr_t;

endpackage

// ==== loop_pred_if.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

interface lp_lookup_if import loop_pred_pkg::*; ();

  lp_idx_t [`LP_SLOTS-1:0] idx;  // One index per slot.
  lp_tag_t [`LP_SLOTS-1:0] tag;

  modport source_mp (output idx, output tag);
  modport table_mp (input idx, input tag);
  modport select_mp (input idx);  // The bimodal table is untagged.

endinterface

interface lp_update_if import loop_pred_pkg::*; ();

  logic valid;  // Single-cycle pulse, always accepted.
  logic is_cond;
  logic taken;
  lp_idx_t idx;
  lp_tag_t tag;

  modport source_mp (
    output valid,
    output is_cond,
    output taken,
    output idx,
    output tag
  );

  modport sink_mp (
    input valid,
    input is_cond,
    input taken,
    input idx,
    input tag
  );

endinterface

// ==== pc_hash.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module pc_hash import loop_pred_pkg::*; (
  input  pc_t                 fetch_pc_i,
  input  logic                upd_valid_i,
  input  logic                upd_is_cond_i,
  input  logic                upd_taken_i,
  input  pc_t                 upd_pc_i,
  lp_lookup_if.source_mp      lookup,
  lp_update_if.source_mp      update
);

  localparam int unsigned INSTR_BYTES = `LP_ILEN / 8;
  localparam int unsigned IDX_LSB = $clog2(INSTR_BYTES);
  localparam int unsigned FOLD_LSB = IDX_LSB + `LP_IDX_BITS;  // First bit above the index.

  pc_t [`LP_SLOTS-1:0] slot_pc;

  function automatic lp_idx_t idx_of(input pc_t pc);
    lp_idx_t fold;
    fold = '0;
    for (int b = FOLD_LSB; b < `LP_PLEN; b++) begin
      fold[(b - FOLD_LSB) % `LP_IDX_BITS] ^= pc[b];
    end
    return pc[IDX_LSB +: `LP_IDX_BITS] ^ fold;
  endfunction

  function automatic lp_tag_t tag_of(input pc_t pc);
    lp_tag_t fold;
    fold = '0;
    for (int b = FOLD_LSB; b < `LP_PLEN; b++) begin
      fold[(b - FOLD_LSB) % `LP_TAG_BITS] ^= pc[b];
    end
    return fold;
  endfunction

  always_comb begin
    for (int i = 0; i < `LP_SLOTS; i++) begin
      slot_pc[i] = fetch_pc_i + pc_t'(i * INSTR_BYTES);  // Slots are consecutive words.
      lookup.idx[i] = idx_of(slot_pc[i]);
      lookup.tag[i] = tag_of(slot_pc[i]);
    end
  end

  // Jumps and other unconditional branches are filtered out here.
  assign update.valid = upd_valid_i && upd_is_cond_i;
  assign update.is_cond = upd_is_cond_i;
  assign update.taken = upd_taken_i;
  assign update.idx = idx_of(upd_pc_i);
  assign update.tag = tag_of(upd_pc_i);

endmodule

// ==== loop_table.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module loop_table import loop_pred_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  lp_lookup_if.table_mp      lookup,
  lp_update_if.sink_mp       update,
  output slot_mask_t         hit_o,
  output slot_mask_t         confident_o,
  output slot_mask_t         loop_taken_o
);

  localparam iter_t ITER_MAX = '1;
  localparam conf_t CONF_MAX = '1;
  localparam conf_t CONF_TH = conf_t'(`LP_CONF_THRESH);

  logic [`LP_ENTRIES-1:0] valid_q;
  lp_tag_t tag_q [`LP_ENTRIES];
  iter_t trip_q [`LP_ENTRIES];  // Taken count seen on the last loop exit.
  iter_t iter_q [`LP_ENTRIES];  // Taken count since the last exit.
  conf_t conf_q [`LP_ENTRIES];

  logic upd_fire;
  logic upd_hit;
  iter_t upd_trip;
  iter_t upd_iter;
  conf_t upd_conf;

  // Lookup reads the state as it stands before any update on this edge.
  always_comb begin
    for (int i = 0; i < `LP_SLOTS; i++) begin
      hit_o[i] = valid_q[lookup.idx[i]] && (tag_q[lookup.idx[i]] == lookup.tag[i]);
      confident_o[i] = hit_o[i] &&
                       (trip_q[lookup.idx[i]] != '0) &&
                       (conf_q[lookup.idx[i]] >= CONF_TH);
      loop_taken_o[i] = confident_o[i] &&
                        (iter_q[lookup.idx[i]] < trip_q[lookup.idx[i]]);
    end
  end

  always_comb begin
    upd_fire = update.valid && update.is_cond;
    upd_hit = valid_q[update.idx] && (tag_q[update.idx] == update.tag);
    upd_trip = trip_q[update.idx];
    upd_iter = iter_q[update.idx];
    upd_conf = conf_q[update.idx];
  end

  // Only a taken miss allocates, so valid bits never clear outside reset.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (upd_fire && !upd_hit && update.taken) begin
      valid_q[update.idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_fire) begin
      if (upd_hit) begin
        if (update.taken) begin
          if (upd_iter != ITER_MAX) begin
            iter_q[update.idx] <= upd_iter + iter_t'(1);  // Another pass through the body.
          end
        end else if (upd_iter != '0) begin
          if (upd_iter == upd_trip) begin
            if (upd_conf != CONF_MAX) begin
              conf_q[update.idx] <= upd_conf + conf_t'(1);  // Same trip count again.
            end
          end else begin
            trip_q[update.idx] <= upd_iter;  // New trip count, start over.
            conf_q[update.idx] <= '0;
          end
          iter_q[update.idx] <= '0;
        end else begin
          // Two exits in a row do not look like a loop.
          if (upd_conf != '0) begin
            conf_q[update.idx] <= upd_conf - conf_t'(1);
          end
        end
      end else if (update.taken) begin
        tag_q[update.idx] <= update.tag;
        trip_q[update.idx] <= '0;
        iter_q[update.idx] <= iter_t'(1);  // This taken update is the first iteration.
        conf_q[update.idx] <= '0;
      end
    end
  end

endmodule

// ==== pred_select.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module pred_select import loop_pred_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  lp_lookup_if.select_mp     lookup,
  lp_update_if.sink_mp       update,
  input  slot_mask_t         confident_i,
  input  slot_mask_t         loop_taken_i,
  output slot_mask_t         taken_o
);

  localparam bim_ctr_t BIM_MAX = '1;
  localparam bim_ctr_t BIM_INIT = bim_ctr_t'(`LP_BIM_INIT);

  bim_ctr_t bim_q [`LP_ENTRIES];

  logic upd_fire;
  bim_ctr_t upd_ctr;
  bim_ctr_t upd_ctr_next;

  // Saturating step toward the resolved direction.
  always_comb begin
    upd_fire = update.valid && update.is_cond;
    upd_ctr = bim_q[update.idx];
    upd_ctr_next = upd_ctr;
    if (update.taken) begin
      if (upd_ctr != BIM_MAX) begin
        upd_ctr_next = upd_ctr + bim_ctr_t'(1);
      end
    end else if (upd_ctr != '0) begin
      upd_ctr_next = upd_ctr - bim_ctr_t'(1);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int e = 0; e < `LP_ENTRIES; e++) begin
        bim_q[e] <= BIM_INIT;  // Weakly not-taken.
      end
    end else if (upd_fire) begin
      bim_q[update.idx] <= upd_ctr_next;
    end
  end

  // A confident loop entry overrides the bimodal guess.
  always_comb begin
    for (int i = 0; i < `LP_SLOTS; i++) begin
      if (confident_i[i]) begin
        taken_o[i] = loop_taken_i[i];
      end else begin
        taken_o[i] = bim_q[lookup.idx[i]][`LP_BIM_BITS-1];  // Counter MSB is the direction.
      end
    end
  end

endmodule

// ==== loop_branch_pred_top.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module loop_branch_pred_top import loop_pred_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  pc_t         fetch_pc_i,
  input  logic        upd_valid_i,
  input  pc_t         upd_pc_i,
  input  logic        upd_is_cond_i,
  input  logic        upd_taken_i,
  output slot_mask_t  hit_o,
  output slot_mask_t  confident_o,
  output slot_mask_t  loop_taken_o,
  output slot_mask_t  taken_o
);

  lp_lookup_if lookup_if ();
  lp_update_if update_if ();

  pc_hash pc_hash_inst (
    .fetch_pc_i    (fetch_pc_i),
    .upd_valid_i   (upd_valid_i),
    .upd_is_cond_i (upd_is_cond_i),
    .upd_taken_i   (upd_taken_i),
    .upd_pc_i      (upd_pc_i),
    .lookup        (lookup_if.source_mp),
    .update        (update_if.source_mp)
  );

  loop_table loop_table_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lookup       (lookup_if.table_mp),
    .update       (update_if.sink_mp),
    .hit_o        (hit_o),
    .confident_o  (confident_o),
    .loop_taken_o (loop_taken_o)
  );

  // The loop results feed the selector and the top outputs alike.
  pred_select pred_select_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lookup       (lookup_if.select_mp),
    .update       (update_if.sink_mp),
    .confident_i  (confident_o),
    .loop_taken_i (loop_taken_o),
    .taken_o      (taken_o)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 20;  // 40 ns clock period.

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset rises just after time zero so the asynchronous reset sees an edge.
  initial begin
    rst_o = 1'b0;
    #1 rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on the second rising edge.
  end

endmodule

// ==== loop_branch_pred_assertions.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module loop_branch_pred_assertions import loop_pred_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input slot_mask_t hit_i,
  input slot_mask_t confident_i,
  input slot_mask_t loop_taken_i,
  input slot_mask_t taken_i
);

  int assert_failures = 0;  // Read by the testbench at the end of the run.

  a_conf_needs_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    (confident_i & ~hit_i) == '0)
    else begin
      assert_failures++;
      $error("Confident prediction in a slot without a table hit.");
    end

  a_loop_taken_needs_conf: assert property (@(posedge clk_i) disable iff (rst_i)
    (loop_taken_i & ~confident_i) == '0)
    else begin
      assert_failures++;
      $error("Loop predicts taken in a slot that is not confident.");
    end

  // Every loop entry is invalid and every counter weakly not-taken in reset.
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |-> (hit_i == '0) && (confident_i == '0) && (loop_taken_i == '0) && (taken_i == '0))
    else begin
      assert_failures++;
      $error("Prediction outputs are not zero during reset.");
    end

  a_no_unknown: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown({hit_i, confident_i, loop_taken_i, taken_i}))
    else begin
      assert_failures++;
      $error("Prediction outputs carry unknown bits after reset.");
    end

endmodule

bind loop_branch_pred_top loop_branch_pred_assertions loop_branch_pred_assertions_inst (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .hit_i        (hit_o),
  .confident_i  (confident_o),
  .loop_taken_i (loop_taken_o),
  .taken_i      (taken_o)
);

// ==== loop_branch_pred_tb.sv ====
`timescale 1ns/1ps
`include "loop_pred_config.svh"

module loop_branch_pred_tb import loop_pred_pkg::*; ();

  localparam int S = `LP_SLOTS;
  localparam int RESET_CYCLES = 4;
  localparam int DIRECTED_CYCLES = 90;
  localparam int RANDOM_CYCLES = 300;
  localparam int MARGIN_CYCLES = 50;
  localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES;

  logic clk_i;
  logic rst_i;
  pc_t fetch_pc;
  logic upd_valid;
  pc_t upd_pc;
  logic upd_is_cond;
  logic upd_taken;
  slot_mask_t hit;
  slot_mask_t confident;
  slot_mask_t loop_taken;
  slot_mask_t taken;

  // Reference copy of both tables.
  logic m_valid [`LP_ENTRIES];
  lp_tag_t m_tag [`LP_ENTRIES];
  int m_trip [`LP_ENTRIES];
  int m_iter [`LP_ENTRIES];
  int m_conf [`LP_ENTRIES];
  int m_bim [`LP_ENTRIES];

  int checks = 0;
  int errors = 0;
  string test_name = "reset";
  logic run_checks = 1'b0;
  logic [31:0] seed = 32'he025;
  pc_t pool [8];

  tb_clock_gen tb_clock_gen_inst (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  loop_branch_pred_top loop_branch_pred_top_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_pc_i    (fetch_pc),
    .upd_valid_i   (upd_valid),
    .upd_pc_i      (upd_pc),
    .upd_is_cond_i (upd_is_cond),
    .upd_taken_i   (upd_taken),
    .hit_o         (hit),
    .confident_o   (confident),
    .loop_taken_o  (loop_taken),
    .taken_o       (taken)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // The 24 bits above bit 7 fold in 6-bit chunks for the index, 10-bit for the tag.
  function automatic lp_idx_t ref_idx(input pc_t pc);
    return pc[7:2] ^ pc[13:8] ^ pc[19:14] ^ pc[25:20] ^ pc[31:26];
  endfunction

  function automatic lp_tag_t ref_tag(input pc_t pc);
    return pc[17:8] ^ pc[27:18] ^ {6'b0, pc[31:28]};
  endfunction

  function automatic void model_reset();
    for (int e = 0; e < `LP_ENTRIES; e++) begin
      m_valid[e] = 1'b0;
      m_bim[e] = 1;
    end
  endfunction

  function automatic void model_update(input pc_t pc, input logic tk);
    lp_idx_t i;
    i = ref_idx(pc);
    if (tk && m_bim[i] < 3) m_bim[i]++;
    else if (!tk && m_bim[i] > 0) m_bim[i]--;
    if (m_valid[i] && m_tag[i] == ref_tag(pc)) begin
      if (tk) begin
        if (m_iter[i] < 255) m_iter[i]++;
      end else if (m_iter[i] != 0) begin
        if (m_iter[i] == m_trip[i]) begin
          if (m_conf[i] < 3) m_conf[i]++;
        end else begin
          m_trip[i] = m_iter[i];
          m_conf[i] = 0;
        end
        m_iter[i] = 0;
      end else if (m_conf[i] > 0) begin
        m_conf[i]--;
      end
    end else if (tk) begin
      m_valid[i] = 1'b1;
      m_tag[i] = ref_tag(pc);
      m_trip[i] = 0;
      m_iter[i] = 1;
      m_conf[i] = 0;
    end
  endfunction

  // Returns {hit, confident, loop_taken, taken} for a fetch block.
  function automatic logic [4*S-1:0] expected_outputs(input pc_t base);
    slot_mask_t h;
    slot_mask_t c;
    slot_mask_t l;
    slot_mask_t t;
    lp_idx_t i;
    pc_t pc;
    for (int s = 0; s < S; s++) begin
      pc = base + pc_t'(4 * s);
      i = ref_idx(pc);
      h[s] = m_valid[i] && (m_tag[i] == ref_tag(pc));
      c[s] = h[s] && (m_trip[i] != 0) && (m_conf[i] >= `LP_CONF_THRESH);
      l[s] = c[s] && (m_iter[i] < m_trip[i]);
      t[s] = c[s] ? l[s] : (m_bim[i] >= 2);
    end
    return {h, c, l, t};
  endfunction

  task automatic check_mask(input string what, input slot_mask_t exp, input slot_mask_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic drive_cycle(input pc_t fpc, input logic uv, input pc_t upc, input logic uc,
                             input logic ut);
    @(posedge clk_i);
    fetch_pc <= fpc;
    upd_valid <= uv;
    upd_pc <= upc;
    upd_is_cond <= uc;
    upd_taken <= ut;
  endtask

  always @(posedge clk_i) begin
    if (rst_i) model_reset();
    else if (upd_valid && upd_is_cond) model_update(upd_pc, upd_taken);  // Pre-edge inputs.
  end

  always @(negedge clk_i) begin
    logic [4*S-1:0] exp;
    if (run_checks) begin
      exp = expected_outputs(fetch_pc);
      check_mask("hit", exp[4*S-1 -: S], hit);
      check_mask("confident", exp[3*S-1 -: S], confident);
      check_mask("loop_taken", exp[2*S-1 -: S], loop_taken);
      check_mask("taken", exp[S-1:0], taken);
    end
  end

  initial begin
    #(TOTAL_CYCLES * 40);
    $display("Timeout: the tests did not finish within %0d cycles.", TOTAL_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    fetch_pc = '0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_is_cond = 1'b0;
    upd_taken = 1'b0;
    wait (rst_i === 1'b1);
    wait (rst_i === 1'b0);
    run_checks = 1'b1;
    repeat (RESET_CYCLES) begin
      seed = lcg_next(seed);
      drive_cycle(seed & 32'hFFFF_FFFC, 1'b0, '0, 1'b0, 1'b0);
    end

    test_name = "alloc";
    drive_cycle(32'h1040, 1'b1, 32'h1040, 1'b1, 1'b1);
    drive_cycle(32'h1040, 1'b0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_mask("hit", 2'b01, hit);
    check_mask("confident", 2'b00, confident);
    drive_cycle(32'h2080, 1'b1, 32'h2080, 1'b1, 1'b0);  // Not-taken miss.
    drive_cycle(32'h30C0, 1'b1, 32'h30C0, 1'b0, 1'b1);  // Unconditional.
    drive_cycle(32'h2080, 1'b0, '0, 1'b0, 1'b0);
    drive_cycle(32'h30C0, 1'b0, '0, 1'b0, 1'b0);

    test_name = "loop_train";
    repeat (5) begin
      repeat (3) drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b1);
      drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b0);
    end
    drive_cycle(32'h4100, 1'b0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_mask("confident", 2'b01, confident);
    check_mask("loop_taken", 2'b01, loop_taken);
    repeat (3) drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b1);
    drive_cycle(32'h4100, 1'b0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_mask("exit", 2'b00, taken & 2'b01);  // Iteration count reached the trip count.
    drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b0);

    test_name = "trip_change";
    repeat (3) begin
      repeat (5) drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b1);
      drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b0);
    end
    drive_cycle(32'h4100, 1'b1, 32'h4100, 1'b1, 1'b0);  // Exit at count zero.
    drive_cycle(32'h4100, 1'b0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_mask("confident", 2'b00, confident);

    test_name = "fallback";
    repeat (4) drive_cycle(32'h5200, 1'b1, 32'h5204, 1'b1, 1'b1);
    repeat (5) drive_cycle(32'h5200, 1'b1, 32'h5204, 1'b1, 1'b0);
    repeat (4) drive_cycle(32'h5200, 1'b1, 32'h5200, 1'b1, 1'b1);
    repeat (5) drive_cycle(32'h5200, 1'b1, 32'h5200, 1'b1, 1'b0);
    drive_cycle(32'h5200, 1'b0, '0, 1'b0, 1'b0);

    // A small pool over few index and tag bits makes entries alias and replace.
    test_name = "random";
    for (int k = 0; k < 8; k++) begin
      seed = lcg_next(seed);
      pool[k] = seed & 32'h0000_0F0C;
    end
    repeat (RANDOM_CYCLES) begin
      seed = lcg_next(seed);
      drive_cycle(pool[seed[18:16]], seed[19] | seed[20],
                  pool[seed[23:21]] + pc_t'({seed[24], 2'b00}),
                  |seed[27:25], seed[28] | seed[29]);
    end
    drive_cycle(pool[0], 1'b0, '0, 1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
    run_checks = 1'b0;

    errors = errors + loop_branch_pred_top_inst.loop_branch_pred_assertions_inst.assert_failures;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== loop_branch_pred_top.f ====
+incdir+.
loop_pred_pkg.sv
loop_pred_if.sv
pc_hash.sv
loop_table.sv
pred_select.sv
loop_branch_pred_top.sv
tb_clock_gen.sv
loop_branch_pred_assertions.sv
loop_branch_pred_tb.sv
